//--- Bender.yml
package:
  name: sprite_engine

sources:
  - include_dirs:
      - source
    files:
      - source/sprite_pkg.sv
      - source/obj_table.sv
      - source/obj_scan.sv
      - source/obj_draw.sv
      - source/obj_line.sv
      - source/sprite_engine.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_clock.sv
      - tb/tb_checker.sv
      - tb/tb_sprite_engine.sv

//--- sim.f
+incdir+source
source/sprite_pkg.sv
source/obj_table.sv
source/obj_scan.sv
source/obj_draw.sv
source/obj_line.sv
source/sprite_engine.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_sprite_engine.sv

//--- source/obj_draw.sv
//----------------------------------------------------------------------------
// Tile drawer
// fetches one ROM row per job and writes its opaque pixels into the
// line buffer, leaving pixels from lower table indexes in place
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "sprite_params.svh"

module obj_draw import sprite_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,

    input  logic               job_valid,
    input  draw_job_t          job,
    output logic               job_ready,
    output logic               idle,

    output logic               rom_req_valid,
    output logic [`ROM_AW-1:0] rom_addr,
    input  logic               rom_req_ready,
    input  logic               rom_rsp_valid,
    input  logic [`ROM_DW-1:0] rom_data,

    output logic               buf_wr,
    output logic [`POS_W-1:0]  buf_addr,
    output pixel_t             buf_pxl,
    output logic [`POS_W-1:0]  buf_rd_addr,
    input  pixel_t             buf_rd_pxl
);

    localparam int POS_W = `POS_W;

    draw_state_e        state;
    draw_job_t          job_q;
    logic [`ROM_DW-1:0] data_q;
    logic [3:0]         cnt;        // 0 to 8, read runs one ahead of write
    logic [2:0]         pix;        // pixel being written
    logic [2:0]         src;        // its nibble in the ROM word
    logic [3:0]         colour;
    logic [POS_W:0]     pos;        // extra bit catches the right edge

    assign job_ready     = state == DRAW_IDLE;
    assign idle          = state == DRAW_IDLE;
    assign rom_req_valid = state == DRAW_REQ;
    assign rom_addr      = job_q.addr;

    assign pix    = cnt[2:0] - 3'd1;
    assign src    = job_q.hflip ? ~pix : pix;   // 7 - pix when flipped
    assign colour = data_q[{src, 2'b00} +: 4];
    assign pos    = {1'b0, job_q.x} + {{(POS_W - 2){1'b0}}, pix};

    assign buf_rd_addr = job_q.x + POS_W'(cnt);
    assign buf_addr    = pos[POS_W-1:0];
    assign buf_pxl     = '{pal: job_q.pal, colour: colour};

    // opaque, on the line, and nothing drawn there yet
    assign buf_wr = state == DRAW_WRITE && cnt != 4'd0 && colour != 4'd0
                    && pos < `LINE_W && buf_rd_pxl.colour == 4'd0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DRAW_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DRAW_IDLE: if (job_valid) state <= DRAW_REQ;
                DRAW_REQ:  if (rom_req_ready) state <= DRAW_WAIT;
                DRAW_WAIT: begin
                    if (rom_rsp_valid) begin
                        cnt   <= '0;
                        state <= DRAW_WRITE;
                    end
                end
                DRAW_WRITE: begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd8) state <= DRAW_IDLE;
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid && job_ready) job_q <= job;
        if (state == DRAW_WAIT && rom_rsp_valid) data_q <= rom_data;
    end

    // one request in flight, so a response outside WAIT is stray
    a_rsp_in_wait: assert property (
        @(posedge clk) disable iff (!arst_n)
        rom_rsp_valid |-> state == DRAW_WAIT
    );

endmodule

//--- source/obj_line.sv
//----------------------------------------------------------------------------
// Line buffer
// two halves, one drawn while the other is shown and cleared
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "sprite_params.svh"

module obj_line import sprite_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              pxl_cen,

    input  logic              start,
    input  logic [`POS_W-1:0] vrender,

    input  logic              buf_wr,
    input  logic [`POS_W-1:0] buf_addr,
    input  pixel_t            buf_pxl,
    input  logic [`POS_W-1:0] buf_rd_addr,
    output pixel_t            buf_rd_pxl,

    input  logic [`POS_W-1:0] hdump,
    output pixel_t            pxl
);

    localparam int AW = $clog2(`LINE_W);

    logic wr_half;      // half being drawn

    for (genvar h = 0; h < 2; h++) begin : g_half
        pixel_t            mem [`LINE_W];
        logic [`LINE_W-1:0] live;   // drawn and not yet shown
        pixel_t            rd_q;
        logic              rd_live;
        pixel_t            rd_pxl;
        pixel_t            shown;
        logic              is_wr;

        assign is_wr  = wr_half == 1'(h);
        assign rd_pxl = rd_live ? rd_q : '0;
        assign shown  = live[hdump[AW-1:0]] ? mem[hdump[AW-1:0]] : '0;

        always_ff @(posedge clk) begin
            if (is_wr && buf_wr) mem[buf_addr[AW-1:0]] <= buf_pxl;
            rd_q <= mem[buf_rd_addr[AW-1:0]];
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                live    <= '0;
                rd_live <= 1'b0;
            end else begin
                rd_live <= live[buf_rd_addr[AW-1:0]];
                if (is_wr) begin
                    if (buf_wr) live[buf_addr[AW-1:0]] <= 1'b1;
                end else if (pxl_cen) begin
                    live[hdump[AW-1:0]] <= 1'b0;    // cleared as it is shown
                end
            end
        end
    end

    assign buf_rd_pxl = wr_half ? g_half[1].rd_pxl : g_half[0].rd_pxl;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_half <= 1'b0;
            pxl     <= '0;
        end else begin
            if (start) wr_half <= vrender[0];
            if (pxl_cen) pxl <= wr_half ? g_half[0].shown : g_half[1].shown;
        end
    end

    // the drawer clips at the right edge
    a_addr_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        buf_wr |-> buf_addr < `LINE_W
    );

endmodule

//--- source/obj_scan.sv
//----------------------------------------------------------------------------
// Line scanner
// walks the object table at line start and issues draw jobs
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "sprite_params.svh"

module obj_scan import sprite_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  start,
    input  logic [`POS_W-1:0]     vrender,
    output logic                  busy,

    output logic [`OBJ_IDX_W-1:0] rd_idx,
    input  obj_entry_t            rd_entry,
    input  logic [`POS_W-1:0]     off_x,
    input  logic [`POS_W-1:0]     off_y,

    output logic                  job_valid,
    output draw_job_t             job,
    input  logic                  job_ready,
    input  logic                  draw_idle,
    output logic                  line_done
);

    localparam int IDX_W  = `OBJ_IDX_W;
    localparam int ROM_AW = `ROM_AW;

    scan_state_e        state;
    logic [IDX_W-1:0]   idx;
    logic [`POS_W-1:0]  line;
    logic [`POS_W-1:0]  row;        // modulo 512
    logic               hit;
    logic               last;
    logic               step;       // move on to the next entry
    logic               pending;    // table done, drawer may still be busy

    assign row    = line + off_y - rd_entry.y;
    assign hit    = rd_entry.en && row < `OBJ_H;
    assign last   = idx == IDX_W'(`OBJ_COUNT - 1);
    assign step   = (state == SCAN_CHECK && !hit) || (state == SCAN_EMIT && job_ready);
    assign busy   = state != SCAN_IDLE;
    assign rd_idx = idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= SCAN_IDLE;
            idx       <= '0;
            job_valid <= 1'b0;
            pending   <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (state)
                SCAN_IDLE: begin
                    if (start) begin
                        idx     <= '0;
                        pending <= 1'b0;
                        state   <= SCAN_READ;
                    end else if (pending && draw_idle) begin
                        pending   <= 1'b0;
                        line_done <= 1'b1;
                    end
                end
                SCAN_READ:  state <= SCAN_CHECK;    // RAM read in flight
                SCAN_CHECK: begin
                    if (hit) begin
                        job_valid <= 1'b1;
                        state     <= SCAN_EMIT;
                    end
                end
                SCAN_EMIT: if (job_ready) job_valid <= 1'b0;
                default:   state <= SCAN_IDLE;
            endcase
            if (step) begin
                if (last) begin
                    pending <= 1'b1;
                    state   <= SCAN_IDLE;
                end else begin
                    idx   <= idx + 1'b1;
                    state <= SCAN_READ;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCAN_IDLE && start) line <= vrender;
        if (state == SCAN_CHECK && hit) begin
            job.addr  <= ROM_AW'(rd_entry.code) * ROM_AW'(`OBJ_H) + ROM_AW'(row);
            job.x     <= rd_entry.x - off_x;
            job.pal   <= rd_entry.pal;
            job.hflip <= rd_entry.hflip;
        end
    end

endmodule

//--- source/obj_table.sv
//----------------------------------------------------------------------------
// Object table
// entry RAM and scroll offsets, loaded by the host, read by the scanner
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "sprite_params.svh"

module obj_table import sprite_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  host_valid,
    input  host_wr_t              host_wr,
    output logic                  host_ready,

    input  logic                  busy,
    input  logic [`OBJ_IDX_W-1:0] rd_idx,
    output obj_entry_t            rd_entry,
    output logic [`POS_W-1:0]     off_x,
    output logic [`POS_W-1:0]     off_y
);

    obj_entry_t            mem [`OBJ_COUNT];
    logic [`OBJ_COUNT-1:0] en_q;    // enable bits live in flops
    obj_entry_t            rd_q;
    logic                  rd_en;
    logic                  wr;

    assign host_ready = !busy;      // table frozen during a scan
    assign wr         = host_valid && host_ready;

    always_ff @(posedge clk) begin
        if (wr && host_wr.target == ENTRY) begin
            mem[host_wr.idx] <= host_wr.entry;
        end
        rd_q <= mem[rd_idx];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_q  <= '0;
            rd_en <= 1'b0;
            off_x <= '0;
            off_y <= '0;
        end else begin
            rd_en <= en_q[rd_idx];
            if (wr) begin
                case (host_wr.target)
                    ENTRY:   en_q[host_wr.idx] <= host_wr.entry.en;
                    OFF_X:   off_x <= host_wr.offset;
                    OFF_Y:   off_y <= host_wr.offset;
                    default: ;
                endcase
            end
        end
    end

    // entry fields from RAM, enable from the reset flops
    always_comb begin
        rd_entry    = rd_q;
        rd_entry.en = rd_en;
    end

    // a write stalled by a scan keeps its data until the table takes it
    a_host_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        host_valid && !host_ready |=> host_valid && $stable(host_wr)
    );

endmodule

//--- source/sprite_engine.sv
//----------------------------------------------------------------------------
// Sprite engine top
// object table, line scanner, tile drawer and line buffer
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "sprite_params.svh"

module sprite_engine import sprite_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               pxl_cen,

    input  logic               start,
    input  logic [`POS_W-1:0]  vrender,    // line being prepared
    input  logic [`POS_W-1:0]  hdump,

    input  logic               host_valid,
    input  host_wr_t           host_wr,
    output logic               host_ready,

    output logic               rom_req_valid,
    output logic [`ROM_AW-1:0] rom_addr,
    input  logic               rom_req_ready,
    input  logic               rom_rsp_valid,
    input  logic [`ROM_DW-1:0] rom_data,

    output pixel_t             pxl
);

    logic                  busy;
    logic [`OBJ_IDX_W-1:0] rd_idx;
    obj_entry_t            rd_entry;
    logic [`POS_W-1:0]     off_x;
    logic [`POS_W-1:0]     off_y;

    logic                  job_valid;
    logic                  job_ready;
    draw_job_t             job;
    logic                  draw_idle;
    logic                  line_done;  // end of the line's work, for debug

    logic                  buf_wr;
    logic [`POS_W-1:0]     buf_addr;
    pixel_t                buf_pxl;
    logic [`POS_W-1:0]     buf_rd_addr;
    pixel_t                buf_rd_pxl;

    obj_table u_table (
        .clk, .arst_n,
        .host_valid, .host_wr, .host_ready,
        .busy, .rd_idx, .rd_entry, .off_x, .off_y
    );

    obj_scan u_scan (
        .clk, .arst_n,
        .start, .vrender, .busy,
        .rd_idx, .rd_entry, .off_x, .off_y,
        .job_valid, .job, .job_ready, .draw_idle, .line_done
    );

    obj_draw u_draw (
        .clk, .arst_n,
        .job_valid, .job, .job_ready,
        .idle (draw_idle),
        .rom_req_valid, .rom_addr, .rom_req_ready, .rom_rsp_valid, .rom_data,
        .buf_wr, .buf_addr, .buf_pxl, .buf_rd_addr, .buf_rd_pxl
    );

    obj_line u_line (
        .clk, .arst_n, .pxl_cen,
        .start, .vrender,
        .buf_wr, .buf_addr, .buf_pxl, .buf_rd_addr, .buf_rd_pxl,
        .hdump, .pxl
    );

endmodule

//--- source/sprite_params.svh
//----------------------------------------------------------------------------
// Sprite engine sizing
// table depth, sprite size, line width and bus widths
//----------------------------------------------------------------------------
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

`define OBJ_COUNT 32  // table entries
`define OBJ_IDX_W 5
`define OBJ_H     16  // lines per sprite
`define LINE_W    256 // pixels per line
`define POS_W     9   // positions wrap at 512
`define CODE_W    12
`define PAL_W     5
`define ROM_AW    17  // code and row
`define ROM_DW    32  // eight 4-bit pixels
`define PXL_W     9   // palette and colour

`endif

//--- source/sprite_pkg.sv
//----------------------------------------------------------------------------
// Sprite engine types
// table entries, host writes, draw jobs, buffer pixels and FSM states
//----------------------------------------------------------------------------
`include "sprite_params.svh"

package sprite_pkg;

    typedef struct packed {
        logic [`POS_W-1:0]  x;
        logic [`POS_W-1:0]  y;
        logic [`CODE_W-1:0] code;
        logic [`PAL_W-1:0]  pal;
        logic               hflip;
        logic               en;     // entry takes part in the scan
    } obj_entry_t;

    typedef enum logic [1:0] {
        ENTRY,
        OFF_X,
        OFF_Y
    } host_target_e;

    typedef struct packed {
        host_target_e          target;
        logic [`OBJ_IDX_W-1:0] idx;
        obj_entry_t            entry;
        logic [`POS_W-1:0]     offset;  // for OFF_X and OFF_Y
    } host_wr_t;

    typedef struct packed {
        logic [`ROM_AW-1:0] addr;   // ROM word for this row
        logic [`POS_W-1:0]  x;      // already scrolled
        logic [`PAL_W-1:0]  pal;
        logic               hflip;
    } draw_job_t;

    typedef struct packed {
        logic [`PAL_W-1:0] pal;
        logic [3:0]        colour;  // 0 is transparent
    } pixel_t;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_CHECK,
        SCAN_EMIT
    } scan_state_e;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_REQ,
        DRAW_WAIT,
        DRAW_WRITE
    } draw_state_e;

endpackage

//--- tb/tb_checker.sv
//----------------------------------------------------------------------------
// Pixel checker
// keeps its own object table and compares every displayed pixel
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "sprite_params.svh"

module tb_checker import sprite_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              pxl_cen,
    input  logic              start,
    input  logic [`POS_W-1:0] vrender,
    input  logic [`POS_W-1:0] hdump,
    input  logic              host_valid,
    input  logic              host_ready,
    input  host_wr_t          host_wr,
    input  logic              line_done,
    input  pixel_t            pxl,
    output int                errors
);

    obj_entry_t         m_ent [`OBJ_COUNT];     // as written by the host
    obj_entry_t         r_ent [`OBJ_COUNT];     // line being drawn
    obj_entry_t         s_ent [`OBJ_COUNT];     // line being shown
    int                 m_offx, m_offy, r_offx, r_offy, s_offx, s_offy;
    int                 r_line, s_line;
    logic               r_valid, s_valid;
    logic [`LINE_W-1:0] seen;                   // positions read since the swap
    logic               pend;
    int                 pend_h;
    pixel_t             pend_exp;
    logic               drawing;                // line started, no line_done yet

    function automatic pixel_t expect_pixel(input int h);
        obj_entry_t e;
        int         i, row, jx, k, addr, src, c;
        pixel_t     p;
        p = '0;
        for (i = 0; i < `OBJ_COUNT; i++) begin
            e   = s_ent[i];
            row = (s_line + s_offy - int'(e.y)) & 511;
            jx  = (int'(e.x) - s_offx) & 511;
            k   = h - jx;
            if (e.en && row < `OBJ_H && k >= 0 && k < 8) begin
                addr = int'(e.code) * `OBJ_H + row;
                src  = e.hflip ? 7 - k : k;
                c    = (addr + src) % 16;
                if (c != 0) begin
                    p.pal    = e.pal;
                    p.colour = c[3:0];
                    return p;   // lowest opaque index wins
                end
            end
        end
        return p;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            foreach (m_ent[i]) m_ent[i] = '0;
            m_offx  = 0;
            m_offy  = 0;
            r_valid = 1'b0;
            s_valid = 1'b0;
            seen    = '0;
            pend    = 1'b0;
            drawing = 1'b0;
            errors  = 0;
        end else begin
            pend = 1'b0;
            if (pxl_cen) begin
                pend_h   = hdump;
                pend_exp = (s_valid && !seen[pend_h]) ? expect_pixel(pend_h) : '0;
                seen[pend_h] = 1'b1;
                pend     = 1'b1;
            end
            if (host_valid && host_ready) begin
                case (host_wr.target)
                    ENTRY:   m_ent[host_wr.idx] = host_wr.entry;
                    OFF_X:   m_offx = host_wr.offset;
                    OFF_Y:   m_offy = host_wr.offset;
                    default: ;
                endcase
            end
            if (line_done) drawing = 1'b0;
            // halves swap, the drawn line moves to the display side
            if (start) begin
                if (drawing) begin
                    errors++;
                    $display("line %0d was still being drawn when line %0d started",
                             r_line, vrender);
                end
                drawing = 1'b1;
                s_ent   = r_ent;
                s_offx  = r_offx;
                s_offy  = r_offy;
                s_line  = r_line;
                s_valid = r_valid;
                r_ent   = m_ent;
                r_offx  = m_offx;
                r_offy  = m_offy;
                r_line  = vrender;
                r_valid = 1'b1;
                seen    = '0;
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n && pend && pxl !== pend_exp) begin
            errors++;
            $display("FAILED at %0t ns: line %0d pixel %0d expected %h got %h",
                     $time, s_line, pend_h, pend_exp, pxl);
        end
    end

endmodule

//--- tb/tb_clock.sv
//----------------------------------------------------------------------------
// Testbench clock and reset
// 100 ns clock, pixel enable every fourth cycle, reset for 8 cycles
//----------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic pxl_cen,
    output logic arst_n
);

    logic [1:0] div = '0;

    initial begin
        clk     = 1'b0;
        pxl_cen = 1'b0;
        arst_n  = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

    always #50 clk = ~clk;

    // enable changes on the falling edge
    always @(negedge clk) begin
        div     <= div + 2'd1;
        pxl_cen <= div == 2'd3;
    end

endmodule

//--- tb/tb_sprite_engine.sv
//----------------------------------------------------------------------------
// Sprite engine testbench
// stimulus table of host writes and lines, ROM model and timeout
//----------------------------------------------------------------------------
`timescale 1ns/1ps
`include "sprite_params.svh"

module tb_sprite_engine import sprite_pkg::*; ();

    localparam int NSTEPS    = 14;
    localparam int LINE_CYC  = `LINE_W * 4 + 300;   // sweep plus writes
    localparam int MAX_CYC   = (NSTEPS + 1) * LINE_CYC + 1000;

    typedef struct packed {
        host_wr_t          wr;
        logic [`POS_W-1:0] line;
        logic              late;    // write issued while the scan runs
    } step_t;

    logic               clk, pxl_cen, arst_n;
    logic               start;
    logic [`POS_W-1:0]  vrender, hdump;
    logic               host_valid, host_ready;
    host_wr_t           host_wr;
    logic               rom_req_valid, rom_req_ready, rom_rsp_valid;
    logic [`ROM_AW-1:0] rom_addr;
    logic [`ROM_DW-1:0] rom_data;
    pixel_t             pxl;
    int                 pix_errors;
    int                 timeouts = 0;
    int                 cycles = 0;
    step_t              steps [$];
    logic               rsp_pend = 1'b0;
    int                 rsp_wait;
    logic [`ROM_AW-1:0] rsp_addr;

    tb_clock u_clock (.clk, .pxl_cen, .arst_n);

    sprite_engine sprite_engine_i (
        .clk, .arst_n, .pxl_cen, .start, .vrender, .hdump,
        .host_valid, .host_wr, .host_ready,
        .rom_req_valid, .rom_addr, .rom_req_ready, .rom_rsp_valid, .rom_data,
        .pxl
    );

    tb_checker u_checker (
        .clk, .arst_n, .pxl_cen, .start, .vrender, .hdump,
        .host_valid, .host_ready, .host_wr,
        .line_done (sprite_engine_i.line_done),
        .pxl, .errors (pix_errors)
    );

    // pixel i of word a is (a + i) mod 16
    function automatic logic [`ROM_DW-1:0] rom_word(input logic [`ROM_AW-1:0] a);
        logic [`ROM_DW-1:0] w;
        for (int i = 0; i < 8; i++) w[4*i +: 4] = 4'(a + i);
        return w;
    endfunction

    always @(posedge clk) begin
        if (arst_n && rom_req_valid && rom_req_ready) begin
            rsp_addr = rom_addr;
            rsp_wait = $urandom_range(3, 0);    // 1 to 4 cycles
            rsp_pend = 1'b1;
        end
    end

    always @(negedge clk) begin
        rom_rsp_valid = 1'b0;
        if (rsp_pend) begin
            if (rsp_wait == 0) begin
                rom_rsp_valid = 1'b1;
                rom_data      = rom_word(rsp_addr);
                rsp_pend      = 1'b0;
            end else begin
                rsp_wait--;
            end
        end
        rom_req_ready = ($urandom % 4) != 0;
    end

    task automatic add_entry(input int idx, x, y, code, pal, hflip, en, line, late);
        step_t s;
        s = '0;
        s.wr.target       = ENTRY;
        s.wr.idx          = idx;
        s.wr.entry.x      = x;
        s.wr.entry.y      = y;
        s.wr.entry.code   = code;
        s.wr.entry.pal    = pal;
        s.wr.entry.hflip  = hflip;
        s.wr.entry.en     = en;
        s.line            = line;
        s.late            = late;
        steps.push_back(s);
    endtask

    task automatic add_offset(input host_target_e t, input int value, line, late);
        step_t s;
        s = '0;
        s.wr.target = t;
        s.wr.offset = value;
        s.line      = line;
        s.late      = late;
        steps.push_back(s);
    endtask

    task automatic host_write(input host_wr_t w);
        @(negedge clk);
        host_valid = 1'b1;
        host_wr    = w;
        do @(posedge clk); while (!host_ready);
        @(negedge clk);
        host_valid = 1'b0;
    endtask

    task automatic pulse_start(input logic [`POS_W-1:0] line);
        @(negedge clk);
        start   = 1'b1;
        vrender = line;
        @(negedge clk);
        start   = 1'b0;
    endtask

    // shows the previous line, one pixel per enable
    task automatic sweep_line();
        for (int h = 0; h < `LINE_W; h++) begin
            @(negedge clk);
            hdump = h;
            do @(posedge clk); while (!pxl_cen);
        end
    endtask

    task automatic print_summary();
        $display("errors: checker %0d, timeout %0d", pix_errors, timeouts);
        if (pix_errors == 0 && timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYC) begin
            timeouts = 1;
            $display("timeout: run did not finish within %0d cycles", MAX_CYC);
            print_summary();
            $finish;
        end
    end

    initial begin
        host_valid    = 1'b0;
        host_wr       = '0;
        start         = 1'b0;
        vrender       = '0;
        hdump         = '0;
        rom_req_ready = 1'b0;
        rom_rsp_valid = 1'b0;
        rom_data      = '0;
        void'($urandom(32'hb504d772));

        add_entry(3, 10, 32, 5, 3, 0, 1, 40, 0);        // single object
        add_entry(3, 10, 32, 5, 3, 1, 1, 41, 0);        // flipped
        add_entry(1, 14, 30, 9, 7, 0, 1, 42, 0);        // overlaps, wins
        add_entry(7, 250, 36, 2, 1, 0, 1, 43, 0);       // clipped at the edge
        add_offset(OFF_X, 4, 44, 0);
        add_offset(OFF_Y, 3, 45, 0);
        add_entry(9, 100, 200, 6, 2, 0, 1, 46, 0);      // outside the window
        add_entry(10, 120, 40, 8, 4, 0, 0, 47, 0);      // disabled
        add_entry(3, 10, 32, 5, 3, 0, 0, 48, 1);
        add_entry(1, 14, 30, 9, 7, 0, 0, 49, 1);
        add_entry(7, 250, 36, 2, 1, 0, 0, 50, 0);
        add_offset(OFF_Y, 0, 51, 0);                    // nothing visible
        add_entry(20, 60, 40, 12'h123, 31, 1, 1, 52, 1);
        add_offset(OFF_X, 0, 53, 0);

        wait (arst_n);
        foreach (steps[i]) begin
            if (!steps[i].late) host_write(steps[i].wr);
            pulse_start(steps[i].line);
            if (steps[i].late) begin
                fork
                    host_write(steps[i].wr);
                    sweep_line();
                join
            end else begin
                sweep_line();
            end
        end
        pulse_start(steps[steps.size() - 1].line + 1'b1);
        sweep_line();
        repeat (4) @(negedge clk);
        print_summary();
        $finish;
    end

endmodule
